// File: Bender.yml
package:
  name: axi_lite_interconnect

sources:
  - axi_lite_pkg.sv
  - axi_lite_decoder.sv
  - axi_lite_write_router.sv
  - axi_lite_read_router.sv
  - axi_lite_interconnect.sv
  - target: test
    files:
      - tb_axi_lite_interconnect.sv

// File: axi_lite_decoder.sv
`timescale 1ns/1ps

module axi_lite_decoder import axi_lite_pkg::*; (
    input  addr_t      i_awaddr,   // Master write address
    input  addr_t      i_araddr,   // Master read address
    output slave_idx_t o_wr_idx,   // Write target, valid with o_wr_hit
    output logic       o_wr_hit,
    output slave_idx_t o_rd_idx,   // Read target, valid with o_rd_hit
    output logic       o_rd_hit
);

    slave_mask_t aw_match;   // Raw region hits, before write filter
    slave_mask_t wr_match;
    slave_mask_t rd_match;

    // One bit per region that contains the address
    function automatic slave_mask_t region_match(input addr_t addr);
        slave_mask_t m;
        m = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            m[i] = ((addr & REGION_MASK[i]) == REGION_BASE[i]);
        end
        return m;
    endfunction

    // Mask to index, regions are disjoint so any hit wins
    function automatic slave_idx_t encode(input slave_mask_t m);
        slave_idx_t idx;
        idx = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (m[i]) idx = slave_idx_t'(i);
        end
        return idx;
    endfunction

    assign aw_match = region_match(i_awaddr);
    assign wr_match = aw_match & WRITE_ENABLE_MASK;   // Read-only slaves drop out here
    assign rd_match = region_match(i_araddr);

    assign o_wr_idx = encode(wr_match);
    assign o_wr_hit = |wr_match;
    assign o_rd_idx = encode(rd_match);
    assign o_rd_hit = |rd_match;   // Miss means local completion in the router

    ////////////////////////////////////////////////////////////
    // Map sanity
    ////////////////////////////////////////////////////////////
    // The base/mask table must not overlap for any address
    aw_no_overlap: assert final ($onehot0(aw_match))
        else $error("write address 0x%08h hits several regions", i_awaddr);
    ar_no_overlap: assert final ($onehot0(rd_match))
        else $error("read address 0x%08h hits several regions", i_araddr);

endmodule

// File: axi_lite_interconnect.sv
`timescale 1ns/1ps

module axi_lite_interconnect import axi_lite_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,

    ////////////////////////////////////////////////////////////
    // Master port, core bus side
    ////////////////////////////////////////////////////////////
    input  logic                   i_m_axi_awvalid,
    output logic                   o_m_axi_awready,
    input  addr_t                  i_m_axi_awaddr,
    input  prot_t                  i_m_axi_awprot,
    input  logic                   i_m_axi_wvalid,
    output logic                   o_m_axi_wready,
    input  data_t                  i_m_axi_wdata,
    input  strb_t                  i_m_axi_wstrb,
    output logic                   o_m_axi_bvalid,
    input  logic                   i_m_axi_bready,
    input  logic                   i_m_axi_arvalid,
    output logic                   o_m_axi_arready,
    input  addr_t                  i_m_axi_araddr,
    input  prot_t                  i_m_axi_arprot,
    output logic                   o_m_axi_rvalid,
    input  logic                   i_m_axi_rready,
    output data_t                  o_m_axi_rdata,

    ////////////////////////////////////////////////////////////
    // Slave ports, bit or element i is slave i
    ////////////////////////////////////////////////////////////
    output addr_t                  o_s_axi_awaddr,    // Shared by all slaves
    output slave_mask_t            o_s_axi_awvalid,
    input  slave_mask_t            i_s_axi_awready,
    output prot_t [NUM_SLAVES-1:0] o_s_axi_awprot,
    output data_t [NUM_SLAVES-1:0] o_s_axi_wdata,
    output strb_t [NUM_SLAVES-1:0] o_s_axi_wstrb,
    output slave_mask_t            o_s_axi_wvalid,
    input  slave_mask_t            i_s_axi_wready,
    input  slave_mask_t            i_s_axi_bvalid,
    output slave_mask_t            o_s_axi_bready,
    output addr_t                  o_s_axi_araddr,    // Shared by all slaves
    output slave_mask_t            o_s_axi_arvalid,
    input  slave_mask_t            i_s_axi_arready,
    output prot_t [NUM_SLAVES-1:0] o_s_axi_arprot,
    input  data_t [NUM_SLAVES-1:0] i_s_axi_rdata,
    input  slave_mask_t            i_s_axi_rvalid,
    output slave_mask_t            o_s_axi_rready
);

    slave_idx_t wr_idx;
    slave_idx_t rd_idx;
    logic       wr_hit;
    logic       rd_hit;

    // Slaves qualify by valid, so addresses go out ungated
    assign o_s_axi_awaddr = i_m_axi_awaddr;
    assign o_s_axi_araddr = i_m_axi_araddr;

    axi_lite_decoder decoder_inst (
        .i_awaddr (i_m_axi_awaddr),
        .i_araddr (i_m_axi_araddr),
        .o_wr_idx (wr_idx),
        .o_wr_hit (wr_hit),
        .o_rd_idx (rd_idx),
        .o_rd_hit (rd_hit)
    );

    // Write and read paths run independently
    axi_lite_write_router write_router_inst (
        .clk         (clk),
        .resetn      (resetn),
        .i_wr_idx    (wr_idx),
        .i_wr_hit    (wr_hit),
        .i_m_awvalid (i_m_axi_awvalid),
        .i_m_awprot  (i_m_axi_awprot),
        .o_m_awready (o_m_axi_awready),
        .i_m_wvalid  (i_m_axi_wvalid),
        .i_m_wdata   (i_m_axi_wdata),
        .i_m_wstrb   (i_m_axi_wstrb),
        .o_m_wready  (o_m_axi_wready),
        .o_m_bvalid  (o_m_axi_bvalid),
        .i_m_bready  (i_m_axi_bready),
        .o_s_awvalid (o_s_axi_awvalid),
        .o_s_awprot  (o_s_axi_awprot),
        .i_s_awready (i_s_axi_awready),
        .o_s_wvalid  (o_s_axi_wvalid),
        .o_s_wdata   (o_s_axi_wdata),
        .o_s_wstrb   (o_s_axi_wstrb),
        .i_s_wready  (i_s_axi_wready),
        .i_s_bvalid  (i_s_axi_bvalid),
        .o_s_bready  (o_s_axi_bready)
    );

    axi_lite_read_router read_router_inst (
        .clk         (clk),
        .resetn      (resetn),
        .i_rd_idx    (rd_idx),
        .i_rd_hit    (rd_hit),
        .i_m_arvalid (i_m_axi_arvalid),
        .i_m_arprot  (i_m_axi_arprot),
        .o_m_arready (o_m_axi_arready),
        .o_m_rvalid  (o_m_axi_rvalid),
        .o_m_rdata   (o_m_axi_rdata),
        .i_m_rready  (i_m_axi_rready),
        .o_s_arvalid (o_s_axi_arvalid),
        .o_s_arprot  (o_s_axi_arprot),
        .i_s_arready (i_s_axi_arready),
        .i_s_rvalid  (i_s_axi_rvalid),
        .i_s_rdata   (i_s_axi_rdata),
        .o_s_rready  (o_s_axi_rready)
    );

endmodule

// File: axi_lite_pkg.sv
package axi_lite_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths and slave count
    ////////////////////////////////////////////////////////////
    localparam int NUM_SLAVES      = 6;
    localparam int ADDR_WIDTH      = 32;
    localparam int DATA_WIDTH      = 32;
    localparam int STRB_WIDTH      = DATA_WIDTH / 8;   // One strobe per byte lane
    localparam int PROT_WIDTH      = 3;
    localparam int SLAVE_IDX_WIDTH = 3;                // Enough for six slaves

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [STRB_WIDTH-1:0]      strb_t;
    typedef logic [PROT_WIDTH-1:0]      prot_t;
    typedef logic [SLAVE_IDX_WIDTH-1:0] slave_idx_t;
    typedef logic [NUM_SLAVES-1:0]      slave_mask_t;  // Bit i stands for slave i

    ////////////////////////////////////////////////////////////
    // Address map, match when (addr & MASK) == BASE
    ////////////////////////////////////////////////////////////
    localparam addr_t REGION_BASE [NUM_SLAVES] = '{
        32'h0000_0000,  // Slave 0, 16 MB
        32'h0100_0000,  // Slave 1, 16 MB, read only
        32'h0200_2000,  // Slave 2, 4 KB
        32'h0200_3000,  // Slave 3, 4 KB
        32'h0300_0000,  // Slave 4, 16 MB
        32'h0200_4000   // Slave 5, 4 KB
    };

    localparam addr_t REGION_MASK [NUM_SLAVES] = '{
        32'hFF00_0000,
        32'hFF00_0000,
        32'hFFFF_F000,
        32'hFFFF_F000,
        32'hFF00_0000,
        32'hFFFF_F000
    };

    // Slave 1 takes no writes
    localparam slave_mask_t WRITE_ENABLE_MASK = 6'b111101;

    // Router FSMs
    typedef enum logic [1:0] {WR_IDLE, WR_ADDR_DATA, WR_RESP} wr_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

endpackage

// File: axi_lite_read_router.sv
`timescale 1ns/1ps

module axi_lite_read_router import axi_lite_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    // From decoder
    input  slave_idx_t             i_rd_idx,
    input  logic                   i_rd_hit,
    // Master side
    input  logic                   i_m_arvalid,
    input  prot_t                  i_m_arprot,
    output logic                   o_m_arready,
    output logic                   o_m_rvalid,
    output data_t                  o_m_rdata,
    input  logic                   i_m_rready,
    // Slave side
    output slave_mask_t            o_s_arvalid,
    output prot_t [NUM_SLAVES-1:0] o_s_arprot,
    input  slave_mask_t            i_s_arready,
    input  slave_mask_t            i_s_rvalid,
    input  data_t [NUM_SLAVES-1:0] i_s_rdata,
    output slave_mask_t            o_s_rready
);

    rd_state_e   state;
    slave_idx_t  idx_q;    // Held until R handshake
    logic        hit_q;
    slave_mask_t sel;      // One-hot target or zero on miss
    logic        in_addr;
    logic        in_data;
    data_t       sel_rdata;

    assign in_addr = (state == RD_ADDR);
    assign in_data = (state == RD_DATA);

    // Target mask and data mux ignoring the other rdata inputs
    always_comb begin
        sel_rdata = '0;   // Miss returns zero
        for (int i = 0; i < NUM_SLAVES; i++) begin
            sel[i]        = hit_q && (idx_q == slave_idx_t'(i));
            o_s_arprot[i] = (in_addr && sel[i]) ? i_m_arprot : '0;
            if (sel[i]) sel_rdata = i_s_rdata[i];
        end
    end

    ////////////////////////////////////////////////////////////
    // Channel steering
    ////////////////////////////////////////////////////////////
    assign o_s_arvalid = (in_addr && i_m_arvalid) ? sel : '0;
    assign o_m_arready = in_addr && (hit_q ? |(i_s_arready & sel) : 1'b1);
    assign o_m_rvalid  = in_data && (hit_q ? |(i_s_rvalid & sel) : 1'b1);
    assign o_m_rdata   = in_data ? sel_rdata : '0;
    assign o_s_rready  = (in_data && i_m_rready) ? sel : '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= RD_IDLE;
            idx_q <= '0;
            hit_q <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (i_m_arvalid) begin
                        idx_q <= i_rd_idx;
                        hit_q <= i_rd_hit;
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (i_m_arvalid && o_m_arready) state <= RD_DATA;
                end
                RD_DATA: begin
                    if (o_m_rvalid && i_m_rready) state <= RD_IDLE;   // Next decode only now
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Slave AR request stays up until that slave takes it
    arvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        |(o_s_arvalid & ~i_s_arready) |=> o_s_arvalid == $past(o_s_arvalid));

    // Stalled R beat keeps valid and data
    rdata_hold: assert property (@(posedge clk) disable iff (!resetn)
        o_m_rvalid && !i_m_rready |=> o_m_rvalid && $stable(o_m_rdata));

endmodule

// File: axi_lite_write_router.sv
`timescale 1ns/1ps

module axi_lite_write_router import axi_lite_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    // From decoder
    input  slave_idx_t             i_wr_idx,
    input  logic                   i_wr_hit,
    // Master side
    input  logic                   i_m_awvalid,
    input  prot_t                  i_m_awprot,
    output logic                   o_m_awready,
    input  logic                   i_m_wvalid,
    input  data_t                  i_m_wdata,
    input  strb_t                  i_m_wstrb,
    output logic                   o_m_wready,
    output logic                   o_m_bvalid,
    input  logic                   i_m_bready,
    // Slave side
    output slave_mask_t            o_s_awvalid,
    output prot_t [NUM_SLAVES-1:0] o_s_awprot,
    input  slave_mask_t            i_s_awready,
    output slave_mask_t            o_s_wvalid,
    output data_t [NUM_SLAVES-1:0] o_s_wdata,
    output strb_t [NUM_SLAVES-1:0] o_s_wstrb,
    input  slave_mask_t            i_s_wready,
    input  slave_mask_t            i_s_bvalid,
    output slave_mask_t            o_s_bready
);

    wr_state_e   state;
    slave_idx_t  idx_q;        // Target held for the whole transaction
    logic        hit_q;        // Low means unmapped and completed locally
    logic        aw_done;      // AW beat already taken
    logic        w_done;       // W beat already taken
    slave_mask_t sel;          // One-hot of latched target or zero on miss
    logic        in_addr;
    logic        in_resp;
    logic        aw_hs;
    logic        w_hs;
    logic        b_hs;

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            sel[i] = hit_q && (idx_q == slave_idx_t'(i));
        end
    end

    assign in_addr = (state == WR_ADDR_DATA);
    assign in_resp = (state == WR_RESP);

    ////////////////////////////////////////////////////////////
    // Master facing handshakes
    ////////////////////////////////////////////////////////////
    // Miss path answers on its own with awready and wready high
    assign o_m_awready = in_addr && !aw_done && (hit_q ? |(i_s_awready & sel) : 1'b1);
    assign o_m_wready  = in_addr && !w_done && (hit_q ? |(i_s_wready & sel) : 1'b1);
    assign o_m_bvalid  = in_resp && (hit_q ? |(i_s_bvalid & sel) : 1'b1);   // Local B on miss

    assign aw_hs = i_m_awvalid && o_m_awready;
    assign w_hs  = i_m_wvalid && o_m_wready;
    assign b_hs  = o_m_bvalid && i_m_bready;

    // Only the latched target sees a slave valid
    assign o_s_awvalid = (in_addr && !aw_done && i_m_awvalid) ? sel : '0;
    assign o_s_wvalid  = (in_addr && !w_done && i_m_wvalid) ? sel : '0;
    assign o_s_bready  = (in_resp && i_m_bready) ? sel : '0;

    // Payload zeroed toward idle slaves
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            o_s_awprot[i] = (in_addr && sel[i]) ? i_m_awprot : '0;
            o_s_wdata[i]  = (in_addr && sel[i]) ? i_m_wdata  : '0;
            o_s_wstrb[i]  = (in_addr && sel[i]) ? i_m_wstrb  : '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Transaction FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= WR_IDLE;
            idx_q   <= '0;
            hit_q   <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (i_m_awvalid) begin   // Decode once and hold till B
                        idx_q   <= i_wr_idx;
                        hit_q   <= i_wr_hit;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= WR_ADDR_DATA;
                    end
                end
                WR_ADDR_DATA: begin
                    if (aw_hs) aw_done <= 1'b1;
                    if (w_hs)  w_done  <= 1'b1;
                    // AW and W may land on different cycles
                    if ((aw_done || aw_hs) && (w_done || w_hs)) state <= WR_RESP;
                end
                WR_RESP: begin
                    if (b_hs) state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Slave AW request stays up until that slave takes it
    awvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        |(o_s_awvalid & ~i_s_awready) |=> o_s_awvalid == $past(o_s_awvalid));

    // B held by slave or local path until master takes it
    bvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        o_m_bvalid && !i_m_bready |=> o_m_bvalid);

endmodule

// File: files.f
axi_lite_pkg.sv
axi_lite_decoder.sv
axi_lite_write_router.sv
axi_lite_read_router.sv
axi_lite_interconnect.sv
tb_axi_lite_interconnect.sv

// File: tb_axi_lite_interconnect.sv
`timescale 1ns/1ps

module tb_axi_lite_interconnect import axi_lite_pkg::*; ();

    localparam int N_TRANS = 200;
    localparam int TIMEOUT = 4100;   // 200 transactions x 20 cycles plus reset

    logic clk;
    logic resetn;
    logic i_m_axi_awvalid, i_m_axi_wvalid, i_m_axi_bready, i_m_axi_arvalid, i_m_axi_rready;
    logic o_m_axi_awready, o_m_axi_wready, o_m_axi_bvalid, o_m_axi_arready, o_m_axi_rvalid;
    addr_t i_m_axi_awaddr, i_m_axi_araddr, o_s_axi_awaddr, o_s_axi_araddr;
    prot_t i_m_axi_awprot, i_m_axi_arprot;
    data_t i_m_axi_wdata, o_m_axi_rdata;
    strb_t i_m_axi_wstrb;
    slave_mask_t o_s_axi_awvalid, o_s_axi_wvalid, o_s_axi_arvalid;
    slave_mask_t o_s_axi_bready, o_s_axi_rready;
    slave_mask_t i_s_axi_awready, i_s_axi_wready, i_s_axi_bvalid;
    slave_mask_t i_s_axi_arready, i_s_axi_rvalid;
    prot_t [NUM_SLAVES-1:0] o_s_axi_awprot, o_s_axi_arprot;
    data_t [NUM_SLAVES-1:0] o_s_axi_wdata, i_s_axi_rdata;
    strb_t [NUM_SLAVES-1:0] o_s_axi_wstrb;

    logic [31:0] rng;                        // LFSR state
    data_t       slv_mem [NUM_SLAVES][8];    // Slave model storage indexed by addr[4:2]
    data_t       ref_mem [NUM_SLAVES][8];    // Expected contents
    logic [2:0]  s_widx [NUM_SLAVES];
    logic [2:0]  s_ridx [NUM_SLAVES];
    data_t       s_wdata [NUM_SLAVES];
    strb_t       s_wstrb [NUM_SLAVES];
    data_t       s_rdata [NUM_SLAVES];       // Held while R beat stalls
    logic [1:0]  wdly [NUM_SLAVES];          // Cycles before write side answers
    logic [1:0]  rdly [NUM_SLAVES];
    slave_mask_t aw_got, w_got, b_pend, r_pend;
    slave_mask_t hs_aw, hs_w, hs_b, hs_ar, hs_r;   // Beats taken at the coming edge
    logic        hs_m_aw, hs_m_w, hs_m_b, hs_m_ar, hs_m_r;
    logic        wr_busy, rd_busy, b_stall, r_stall;
    int          wr_rgn, rd_rgn;             // -1 when unmapped
    int          n_issued, n_done, n_cycles, n_errors;
    data_t       r_last;

    axi_lite_interconnect axi_lite_interconnect_inst (.*);

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb  = rng[31] ^ rng[21] ^ rng[1] ^ rng[0];
            rng = {rng[30:0], fb};
            r   = {r[30:0], fb};
        end
        return r;
    endfunction

    // Memory map of the bus
    function automatic int region_of(input addr_t a);
        if (a[31:24] == 8'h00) return 0;
        if (a[31:24] == 8'h01) return 1;
        if (a[31:12] == 20'h02002) return 2;
        if (a[31:12] == 20'h02003) return 3;
        if (a[31:24] == 8'h03) return 4;
        if (a[31:12] == 20'h02004) return 5;
        return -1;
    endfunction

    function automatic addr_t random_addr();
        logic [2:0] pick;
        addr_t      off;
        pick = 3'(take_bits(3));
        off  = take_bits(24) & 32'h00FF_FFFC;   // Word aligned
        case (pick)
            3'd0: return off;
            3'd1: return 32'h0100_0000 | off;
            3'd2: return 32'h0200_2000 | off[11:0];
            3'd3: return 32'h0200_3000 | off[11:0];
            3'd4: return 32'h0300_0000 | off;
            3'd5: return 32'h0200_4000 | off[11:0];
            3'd6: return 32'h0200_0000 | off[12:0];   // Hole below slave 2
            default: return 32'h0500_0000 | off;      // Far outside the map
        endcase
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t strb);
        data_t m;
        m = old;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) m[8*b +: 8] = nw[8*b +: 8];
        end
        return m;
    endfunction

    function automatic slave_mask_t one_hot(input int rgn);
        return (rgn < 0) ? slave_mask_t'(0) : slave_mask_t'(1 << rgn);
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic stop_run();
        n_errors++;
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input slave_mask_t exp, input slave_mask_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Per cycle model steps
    ////////////////////////////////////////////////////////////
    task automatic apply_beats();
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (hs_aw[s]) aw_got[s] = 1'b1;
            if (hs_w[s]) w_got[s] = 1'b1;
            if (hs_b[s]) b_pend[s] = 1'b0;
            if (hs_r[s]) r_pend[s] = 1'b0;
            if (aw_got[s] && w_got[s]) begin   // Commit then answer with B
                slv_mem[s][s_widx[s]] = merge_bytes(
                    slv_mem[s][s_widx[s]], s_wdata[s], s_wstrb[s]);
                {aw_got[s], w_got[s], b_pend[s]} = 3'b001;
            end
            if (hs_ar[s]) begin
                r_pend[s]  = 1'b1;
                s_rdata[s] = slv_mem[s][s_ridx[s]];
            end
            if (hs_aw[s] || hs_w[s] || hs_b[s]) wdly[s] = 2'(take_bits(2));
            else if (wdly[s] != 0) wdly[s]--;
            if (hs_ar[s] || hs_r[s]) rdly[s] = 2'(take_bits(2));
            else if (rdly[s] != 0) rdly[s]--;
        end
        if (hs_m_aw) i_m_axi_awvalid = 1'b0;
        if (hs_m_w) i_m_axi_wvalid = 1'b0;
        if (hs_m_ar) i_m_axi_arvalid = 1'b0;
        if (hs_m_b) begin   // Slave 1 and holes keep their contents
            if (wr_rgn >= 0 && wr_rgn != 1) begin
                ref_mem[wr_rgn][i_m_axi_awaddr[4:2]] = merge_bytes(
                    ref_mem[wr_rgn][i_m_axi_awaddr[4:2]], i_m_axi_wdata, i_m_axi_wstrb);
            end
            wr_busy = 1'b0;
            n_done++;
        end
        if (hs_m_r) begin
            rd_busy = 1'b0;
            n_done++;
        end
    endtask

    // New transaction that avoids the slave busy in the other direction
    task automatic start_next();
        addr_t a;
        int    rgn;
        logic  is_write;
        if (n_issued == N_TRANS) return;
        is_write = 1'(take_bits(1));
        a        = random_addr();
        rgn      = region_of(a);
        if (is_write && !wr_busy && !(rd_busy && rgn >= 0 && rgn == rd_rgn)) begin
            i_m_axi_awaddr  = a;
            i_m_axi_awprot  = 3'(take_bits(3));
            i_m_axi_wdata   = take_bits(32);
            i_m_axi_wstrb   = 4'(take_bits(4));
            i_m_axi_awvalid = 1'b1;
            i_m_axi_wvalid  = 1'b1;
            wr_busy = 1'b1;
            wr_rgn  = rgn;
            n_issued++;
        end else if (!is_write && !rd_busy && !(wr_busy && rgn >= 0 && rgn == wr_rgn)) begin
            i_m_axi_araddr  = a;
            i_m_axi_arprot  = 3'(take_bits(3));
            i_m_axi_arvalid = 1'b1;
            rd_busy = 1'b1;
            rd_rgn  = rgn;
            n_issued++;
        end
    endtask

    task automatic drive_inputs();
        for (int s = 0; s < NUM_SLAVES; s++) begin
            i_s_axi_awready[s] = !aw_got[s] && !b_pend[s] && wdly[s] == 0;
            i_s_axi_wready[s]  = !w_got[s] && !b_pend[s] && wdly[s] == 0;
            i_s_axi_bvalid[s]  = b_pend[s] && wdly[s] == 0;
            i_s_axi_arready[s] = !r_pend[s] && rdly[s] == 0;
            i_s_axi_rvalid[s]  = r_pend[s] && rdly[s] == 0;
            i_s_axi_rdata[s]   = r_pend[s] ? s_rdata[s] : ~slv_mem[s][0];   // Idle slaves show noise
        end
        i_m_axi_bready = wr_busy & (take_bits(2) != 0);   // Random back-pressure
        i_m_axi_rready = rd_busy & (take_bits(2) != 0);
    endtask

    task automatic sample_and_check();
        slave_mask_t wr_mask;
        slave_mask_t rd_mask;
        data_t       exp_rd;
        wr_mask = (wr_busy && wr_rgn != 1) ? one_hot(wr_rgn) : '0;   // Slave 1 read only
        rd_mask = rd_busy ? one_hot(rd_rgn) : '0;
        hs_aw   = o_s_axi_awvalid & i_s_axi_awready;
        hs_w    = o_s_axi_wvalid & i_s_axi_wready;
        hs_b    = i_s_axi_bvalid & o_s_axi_bready;
        hs_ar   = o_s_axi_arvalid & i_s_axi_arready;
        hs_r    = i_s_axi_rvalid & o_s_axi_rready;
        hs_m_aw = i_m_axi_awvalid && o_m_axi_awready;
        hs_m_w  = i_m_axi_wvalid && o_m_axi_wready;
        hs_m_b  = o_m_axi_bvalid && i_m_axi_bready;
        hs_m_ar = i_m_axi_arvalid && o_m_axi_arready;
        hs_m_r  = o_m_axi_rvalid && i_m_axi_rready;
        if (|o_s_axi_awvalid) check_mask("aw route", wr_mask, o_s_axi_awvalid);
        if (|o_s_axi_wvalid) check_mask("w route", wr_mask, o_s_axi_wvalid);
        if (|o_s_axi_arvalid) check_mask("ar route", rd_mask, o_s_axi_arvalid);
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (!wr_mask[s]) begin   // Untargeted slaves see zero payload
                check_data("idle wdata", '0, o_s_axi_wdata[s]);
                check_data("idle wstrb awprot", '0,
                    data_t'({o_s_axi_wstrb[s], o_s_axi_awprot[s]}));
            end
            if (!rd_mask[s]) check_data("idle arprot", '0, data_t'(o_s_axi_arprot[s]));
            if (hs_aw[s]) begin
                s_widx[s] = o_s_axi_awaddr[4:2];
                check_data("awaddr at slave", i_m_axi_awaddr, o_s_axi_awaddr);
                check_data("awprot at slave", data_t'(i_m_axi_awprot),
                    data_t'(o_s_axi_awprot[s]));
            end
            if (hs_w[s]) begin
                s_wdata[s] = o_s_axi_wdata[s];
                s_wstrb[s] = o_s_axi_wstrb[s];
                check_data("wdata at slave", i_m_axi_wdata, o_s_axi_wdata[s]);
                check_data("wstrb at slave", data_t'(i_m_axi_wstrb),
                    data_t'(o_s_axi_wstrb[s]));
            end
            if (hs_ar[s]) begin
                s_ridx[s] = o_s_axi_araddr[4:2];
                check_data("araddr at slave", i_m_axi_araddr, o_s_axi_araddr);
                check_data("arprot at slave", data_t'(i_m_axi_arprot),
                    data_t'(o_s_axi_arprot[s]));
            end
        end
        if (hs_m_r) begin
            if (rd_rgn < 0) exp_rd = '0;
            else exp_rd = ref_mem[rd_rgn][i_m_axi_araddr[4:2]];
            check_data("read data", exp_rd, o_m_axi_rdata);
        end
        // Stalled responses hold and no new request goes out meanwhile
        if (b_stall) check_bit("bvalid held", 1'b1, o_m_axi_bvalid);
        if (r_stall) begin
            check_bit("rvalid held", 1'b1, o_m_axi_rvalid);
            check_data("rdata held", r_last, o_m_axi_rdata);
        end
        if (wr_busy && !i_m_axi_awvalid && !i_m_axi_wvalid)
            check_mask("slave aw w during B", '0, o_s_axi_awvalid | o_s_axi_wvalid);
        if (rd_busy && !i_m_axi_arvalid) check_mask("slave ar during R", '0, o_s_axi_arvalid);
        b_stall = o_m_axi_bvalid && !i_m_axi_bready;
        r_stall = o_m_axi_rvalid && !i_m_axi_rready;
        r_last  = o_m_axi_rdata;
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, watchdog, main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        n_cycles <= n_cycles + 1;
        if (n_cycles == TIMEOUT) begin
            $display("Timeout: only %0d of %0d transactions done", n_done, N_TRANS);
            stop_run();
        end
    end

    initial begin
        rng    = 32'h3aca_8c83;
        resetn = 1'b0;
        {i_m_axi_awvalid, i_m_axi_wvalid, i_m_axi_arvalid} = '0;
        {i_m_axi_awaddr, i_m_axi_araddr, i_m_axi_wdata} = '0;
        {i_m_axi_awprot, i_m_axi_arprot, i_m_axi_wstrb} = '0;
        {aw_got, w_got, b_pend, r_pend, hs_aw, hs_w, hs_b, hs_ar, hs_r} = '0;
        {hs_m_aw, hs_m_w, hs_m_b, hs_m_ar, hs_m_r, wr_busy, rd_busy, b_stall, r_stall} = '0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            for (int i = 0; i < 8; i++) begin
                slv_mem[s][i] = {8'(s) ^ 8'h5A, 8'(i), 8'(8 * s + i), 8'hC3};
            end
            wdly[s] = '0;
            rdly[s] = '0;
        end
        ref_mem = slv_mem;
        drive_inputs();
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #1;
        check_mask("reset slave valids", '0, o_s_axi_awvalid | o_s_axi_wvalid | o_s_axi_arvalid);
        check_mask("reset slave readies", '0, o_s_axi_bready | o_s_axi_rready);
        check_bit("reset master signals", 1'b0, o_m_axi_awready | o_m_axi_wready
            | o_m_axi_bvalid | o_m_axi_arready | o_m_axi_rvalid);
        while (n_done < N_TRANS) begin
            @(negedge clk);
            apply_beats();
            start_next();
            drive_inputs();
            #1;   // Let the combinational paths settle
            sample_and_check();
        end
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
